//--- mmuPkg.sv
package mmuPkg;

  // One core access as seen at the request edge
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic        wordAccess;
    logic        supMode;
  } cpuReq_t;

  typedef struct packed {
    logic        enable;    // Translation on
    logic        sBit;
    logic        rBit;
    logic [17:0] tBase;     // First-level table base, bits 31:14
    logic [31:0] dom;       // Sixteen 2-bit domain fields
  } mmuCtrl_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        request;
    logic        write;
  } busReq_t;

  // First-level descriptor word, read either as a section or as a coarse table pointer
  typedef union packed {
    struct packed {
      logic [11:0] base;
      logic [7:0]  rsvdHi;
      logic [1:0]  ap;
      logic        rsvdMid;
      logic [3:0]  domain;
      logic [2:0]  rsvdLo;
      logic [1:0]  descType;
    } section;
    struct packed {
      logic [21:0] base;
      logic        rsvdMid;
      logic [3:0]  domain;
      logic [2:0]  rsvdLo;
      logic [1:0]  descType;
    } coarse;
  } firstDesc_u;

  typedef enum logic [3:0] {
    codeAlign        = 4'b0001,
    codeExtFirst     = 4'b1100,
    codeExtSecond    = 4'b1110,
    codeTransSection = 4'b0101,
    codeTransPage    = 4'b0111,
    codeDomSection   = 4'b1001,
    codeDomPage      = 4'b1011,
    codePermSection  = 4'b1101,
    codePermPage     = 4'b1111
  } faultCode_e;

  typedef struct packed {
    logic       fault;
    faultCode_e code;
    logic [3:0] domain;
  } faultInfo_t;

  // First-level types
  localparam logic [1:0] descInvalid = 2'b00;
  localparam logic [1:0] descCoarse  = 2'b01;
  localparam logic [1:0] descSection = 2'b10;
  // Second-level types
  localparam logic [1:0] descLarge   = 2'b01;
  localparam logic [1:0] descSmall   = 2'b10;

  // Which descriptor the final translation comes from
  localparam logic [1:0] stageSection = 2'd0;
  localparam logic [1:0] stageSmall   = 2'd1;
  localparam logic [1:0] stageLarge   = 2'd2;

endpackage

//--- cpuPort.sv
`timescale 1ns/1ps

module cpuPort (
  input  logic             clk,
  input  logic             reset,
  input  logic             CPUHRequest,
  input  logic             CPUHWrite,
  input  logic             WordAccess,
  input  logic             SupMode,
  input  logic [31:0]      CPUHAddr,
  input  logic [31:0]      Cont,
  input  logic [31:0]      Dom,
  input  logic [17:0]      TBase,
  input  logic             done,
  output mmuPkg::cpuReq_t  req,
  output mmuPkg::mmuCtrl_t ctrl,
  output logic             reqValid,
  output logic             alignFault
);

  logic reqFresh;  // High only in the first cycle of reqValid

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      reqValid <= 1'b0;
      reqFresh <= 1'b0;
      ctrl     <= '0;
    end else begin
      // S and R sit at bits 8 and 9 of the control word
      ctrl     <= '{enable: Cont[0], sBit: Cont[8], rBit: Cont[9],
                    tBase: TBase, dom: Dom};
      reqFresh <= CPUHRequest & ~reqValid & ~done;
      if (done)
        reqValid <= 1'b0;
      else if (CPUHRequest)
        reqValid <= 1'b1;
    end
  end

  // Capture the access once, when it is first seen
  always_ff @(posedge clk) begin
    if (CPUHRequest && !reqValid) begin
      req <= '{addr: CPUHAddr, write: CPUHWrite, wordAccess: WordAccess,
               supMode: SupMode};
    end
  end

  // Word access must have a zero low address pair
  assign alignFault = reqFresh & ctrl.enable & req.wordAccess &
                      (req.addr[1:0] != 2'b00);

endmodule

//--- tableWalker.sv
`timescale 1ns/1ps

module tableWalker (
  input  logic               clk,
  input  logic               reset,
  input  mmuPkg::cpuReq_t    req,
  input  mmuPkg::mmuCtrl_t   ctrl,
  input  logic               reqValid,
  input  logic               alignFault,
  input  logic [31:0]        HRData,
  input  logic               HReady,
  input  logic               MMUExtInt,
  input  logic               domainFault,
  input  logic               permFault,
  output mmuPkg::busReq_t    walkBus,
  output logic               walkDone,
  output mmuPkg::firstDesc_u desc1,
  output logic [31:0]        desc2,
  output logic [1:0]         stage,
  output mmuPkg::faultInfo_t candidate,
  output logic               faultValid
);

  typedef enum logic [1:0] {idle, firstFetch, secondFetch, dataAccess} walkState_t;

  walkState_t         state;
  walkState_t         nextState;
  mmuPkg::firstDesc_u fetched;    // Word on the bus, seen through the union
  logic               transFault;
  logic               dataFault;  // Any check failing before the data beat
  logic [31:0]        physAddr;

  assign fetched = HRData;

  // Sections must be type 10; fine tables also land here and fault
  always_comb begin
    if (stage == mmuPkg::stageSection)
      transFault = desc1.section.descType != mmuPkg::descSection;
    else
      transFault = !(desc2[1:0] inside {mmuPkg::descSmall, mmuPkg::descLarge});
  end

  assign dataFault = (state == dataAccess) & (transFault | domainFault | permFault);

  always_comb begin
    nextState        = state;
    candidate.fault  = 1'b0;
    candidate.code   = mmuPkg::codeAlign;
    candidate.domain = desc1.section.domain;
    case (state)
      idle: begin
        if (reqValid && ctrl.enable && !alignFault)
          nextState = firstFetch;
      end
      firstFetch: begin
        if (HReady) begin
          if (MMUExtInt) begin
            candidate.fault  = 1'b1;
            candidate.code   = mmuPkg::codeExtFirst;
            candidate.domain = 4'h0;  // Descriptor never arrived
            nextState        = idle;
          end else if (fetched.section.descType == mmuPkg::descInvalid) begin
            candidate.fault  = 1'b1;
            candidate.code   = mmuPkg::codeTransSection;
            candidate.domain = fetched.section.domain;
            nextState        = idle;
          end else if (fetched.coarse.descType == mmuPkg::descCoarse) begin
            nextState = secondFetch;
          end else begin
            nextState = dataAccess;
          end
        end
      end
      secondFetch: begin
        if (HReady) begin
          if (MMUExtInt) begin
            candidate.fault = 1'b1;
            candidate.code  = mmuPkg::codeExtSecond;
            nextState       = idle;
          end else begin
            nextState = dataAccess;
          end
        end
      end
      dataAccess: begin
        candidate.fault = dataFault;
        if (transFault)
          candidate.code = (stage == mmuPkg::stageSection) ?
                           mmuPkg::codeTransSection : mmuPkg::codeTransPage;
        else if (domainFault)
          candidate.code = (stage == mmuPkg::stageSection) ?
                           mmuPkg::codeDomSection : mmuPkg::codeDomPage;
        else
          candidate.code = (stage == mmuPkg::stageSection) ?
                           mmuPkg::codePermSection : mmuPkg::codePermPage;
        if (dataFault || HReady)
          nextState = idle;
      end
      default: nextState = idle;
    endcase
  end

  assign faultValid = candidate.fault;

  always_ff @(posedge clk, posedge reset) begin
    if (reset)
      state <= idle;
    else
      state <= nextState;
  end

  // Descriptor capture on the completing beat
  always_ff @(posedge clk) begin
    if (state == firstFetch && HReady) begin
      desc1 <= fetched;
      stage <= mmuPkg::stageSection;
    end
    if (state == secondFetch && HReady) begin
      desc2 <= HRData;
      stage <= (HRData[1:0] == mmuPkg::descLarge) ? mmuPkg::stageLarge : mmuPkg::stageSmall;
    end
  end

  always_comb begin
    case (state)
      firstFetch:  physAddr = {ctrl.tBase, req.addr[31:20], 2'b00};
      secondFetch: physAddr = {desc1.coarse.base, req.addr[19:12], 2'b00};
      default: begin
        case (stage)
          mmuPkg::stageSmall: physAddr = {desc2[31:12], req.addr[11:0]};
          mmuPkg::stageLarge: physAddr = {desc2[31:16], req.addr[15:0]};
          default:            physAddr = {desc1.section.base, req.addr[19:0]};
        endcase
      end
    endcase
  end

  // Request held high through wait states; dropped when the checks fail
  assign walkBus = '{addr: physAddr,
                     request: (state == firstFetch) | (state == secondFetch) |
                              ((state == dataAccess) & ~dataFault),
                     write: (state == dataAccess) & req.write};

  assign walkDone = (state == dataAccess) & ~dataFault & HReady;

endmodule

//--- accessCheck.sv
`timescale 1ns/1ps

module accessCheck (
  input  mmuPkg::firstDesc_u desc1,
  input  logic [31:0]        desc2,
  input  logic [1:0]         stage,
  input  logic [31:0]        addr,
  input  logic               write,
  input  logic               supMode,
  input  logic               sBit,
  input  logic               rBit,
  input  logic [31:0]        dom,
  output logic               domainFault,
  output logic               permFault
);

  logic [1:0] dPerm;   // Domain access field
  logic [1:0] subSel;  // Sub-page index
  logic [1:0] pageAp;
  logic [1:0] curAp;
  logic       apFault;

  // Domain bits sit in the same place in both descriptor views
  assign dPerm = dom[{desc1.section.domain, 1'b0} +: 2];
  assign domainFault = (dPerm == 2'b00);

  // Large pages pick their quarter with bits 15:14, small pages with 11:10
  assign subSel = (stage == mmuPkg::stageLarge) ? addr[15:14] : addr[11:10];

  always_comb begin
    case (subSel)
      2'b00:   pageAp = desc2[5:4];
      2'b01:   pageAp = desc2[7:6];
      2'b10:   pageAp = desc2[9:8];
      default: pageAp = desc2[11:10];
    endcase
  end

  assign curAp = (stage == mmuPkg::stageSection) ? desc1.section.ap : pageAp;

  always_comb begin
    case (curAp)
      2'b00: begin
        case ({sBit, rBit})
          2'b10:   apFault = ~supMode | write;  // Supervisor read only
          2'b01:   apFault = write;             // Read only for both
          default: apFault = 1'b1;              // No access, or S and R both set
        endcase
      end
      2'b01:   apFault = ~supMode;
      2'b10:   apFault = ~supMode & write;  // User read only
      default: apFault = 1'b0;
    endcase
  end

  // Only clients are checked; managers skip the AP bits
  assign permFault = apFault & (dPerm == 2'b01);

endmodule

//--- faultReporter.sv
`timescale 1ns/1ps

module faultReporter (
  input  logic               clk,
  input  logic               reset,
  input  logic               alignFault,
  input  mmuPkg::faultInfo_t candidate,
  input  logic               faultValid,
  input  logic [31:0]        addr,
  output logic               Fault,
  output logic [7:0]         FSR,
  output logic [31:0]        FAR
);

  mmuPkg::faultInfo_t chosen;

  // Alignment is checked before any walk starts, so it wins
  always_comb begin
    if (alignFault) begin
      chosen.fault  = 1'b1;
      chosen.code   = mmuPkg::codeAlign;
      chosen.domain = 4'h0;
    end else begin
      chosen       = candidate;
      chosen.fault = faultValid;
    end
  end

  assign Fault = chosen.fault;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      FSR <= 8'h00;
      FAR <= 32'h0000_0000;
    end else if (chosen.fault) begin
      FSR <= {chosen.domain, chosen.code};  // Domain in the upper nibble
      FAR <= addr;
    end
  end

endmodule

//--- busDriver.sv
`timescale 1ns/1ps

module busDriver (
  input  logic            enable,
  input  logic [31:0]     CPUHAddr,
  input  logic            CPUHRequest,
  input  logic            CPUHWrite,
  input  logic            HReady,
  input  mmuPkg::busReq_t walkBus,
  input  logic            walkDone,
  output logic [31:0]     HAddr,
  output logic            HRequest,
  output logic            HWrite,
  output logic            CPUHReady
);

  // Bypass path is purely combinational
  always_comb begin
    if (enable) begin
      HAddr     = walkBus.addr;
      HRequest  = walkBus.request;
      HWrite    = walkBus.write;
      CPUHReady = walkDone;  // Only the data beat ends the access
    end else begin
      HAddr     = CPUHAddr;
      HRequest  = CPUHRequest;
      HWrite    = CPUHWrite;
      CPUHReady = HReady;
    end
  end

endmodule

//--- mmuTop.sv
`timescale 1ns/1ps

module mmuTop (
  input  logic        clk,
  input  logic        reset,
  input  logic        CPUHRequest,
  input  logic        CPUHWrite,
  input  logic        WordAccess,
  input  logic        SupMode,
  input  logic [31:0] CPUHAddr,
  input  logic [31:0] Cont,
  input  logic [31:0] Dom,
  input  logic [17:0] TBase,
  input  logic        MMUExtInt,
  input  logic [31:0] HRData,
  input  logic        HReady,
  output logic [31:0] HAddr,
  output logic        HRequest,
  output logic        HWrite,
  output logic        CPUHReady,
  output logic        Fault,
  output logic [7:0]  FSR,
  output logic [31:0] FAR
);

  mmuPkg::cpuReq_t    req;
  mmuPkg::mmuCtrl_t   ctrl;
  mmuPkg::busReq_t    walkBus;
  mmuPkg::firstDesc_u desc1;
  mmuPkg::faultInfo_t candidate;
  logic [31:0]        desc2;
  logic [1:0]         stage;
  logic               reqValid, alignFault, done;
  logic               walkDone, faultValid, domainFault, permFault;

  assign done = CPUHReady | Fault;  // Either ends the current access

  cpuPort port (
    .clk(clk), .reset(reset), .CPUHRequest(CPUHRequest), .CPUHWrite(CPUHWrite),
    .WordAccess(WordAccess), .SupMode(SupMode), .CPUHAddr(CPUHAddr), .Cont(Cont),
    .Dom(Dom), .TBase(TBase), .done(done), .req(req), .ctrl(ctrl),
    .reqValid(reqValid), .alignFault(alignFault)
  );

  tableWalker walker (
    .clk(clk), .reset(reset), .req(req), .ctrl(ctrl), .reqValid(reqValid),
    .alignFault(alignFault), .HRData(HRData), .HReady(HReady), .MMUExtInt(MMUExtInt),
    .domainFault(domainFault), .permFault(permFault), .walkBus(walkBus),
    .walkDone(walkDone), .desc1(desc1), .desc2(desc2), .stage(stage),
    .candidate(candidate), .faultValid(faultValid)
  );

  accessCheck check (
    .desc1(desc1), .desc2(desc2), .stage(stage), .addr(req.addr), .write(req.write),
    .supMode(req.supMode), .sBit(ctrl.sBit), .rBit(ctrl.rBit), .dom(ctrl.dom),
    .domainFault(domainFault), .permFault(permFault)
  );

  faultReporter reporter (
    .clk(clk), .reset(reset), .alignFault(alignFault), .candidate(candidate),
    .faultValid(faultValid), .addr(req.addr), .Fault(Fault), .FSR(FSR), .FAR(FAR)
  );

  busDriver driver (
    .enable(ctrl.enable), .CPUHAddr(CPUHAddr), .CPUHRequest(CPUHRequest),
    .CPUHWrite(CPUHWrite), .HReady(HReady), .walkBus(walkBus), .walkDone(walkDone),
    .HAddr(HAddr), .HRequest(HRequest), .HWrite(HWrite), .CPUHReady(CPUHReady)
  );

endmodule

//--- tbMem.sv
`timescale 1ns/1ps

module tbMem (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] HAddr,
  input  logic        HRequest,
  output logic [31:0] HRData,
  output logic        HReady,
  output logic        MMUExtInt
);

  localparam logic [31:0] tableBase = 32'h0001_0000;  // TBase of 18'h4
  localparam logic [31:0] abortAddr = 32'h0001_0024;  // First-level entry for VA 0x009xxxxx

  logic [31:0] words [0:8191];  // Tables from 0x10000 to 0x17FFF
  logic [1:0]  waitCnt;
  logic        inTables;
  integer      seed = 32'hfc4b;

  function automatic logic [31:0] sectionDesc(input logic [11:0] base, input logic [1:0] ap,
                                              input logic [3:0] domain);
    return {base, 8'h00, ap, 1'b0, domain, 3'b000, 2'b10};
  endfunction

  function automatic logic [31:0] coarseDesc(input logic [21:0] base, input logic [3:0] domain);
    return {base, 1'b0, domain, 3'b000, 2'b01};
  endfunction

  // Same AP for all four sub-pages
  function automatic logic [31:0] smallDesc(input logic [19:0] base, input logic [1:0] ap);
    return {base, ap, ap, ap, ap, 2'b00, 2'b10};
  endfunction

  function automatic logic [31:0] largeDesc(input logic [15:0] base, input logic [1:0] ap);
    return {base, 4'h0, ap, ap, ap, ap, 2'b00, 2'b01};
  endfunction

  initial begin
    // Unused entries hold their own address, so type bits read as invalid
    for (int i = 0; i < 8192; i++)
      words[13'(i)] = tableBase + 32'(i) * 32'd4;
    words[13'h003]  = sectionDesc(12'h80A, 2'b11, 4'd1);
    words[13'h004]  = sectionDesc(12'h123, 2'b00, 4'd0);  // Manager domain
    words[13'h005]  = coarseDesc(22'h50, 4'd1);           // Table at 0x14000
    words[13'h006]  = 32'h0000_0000;
    words[13'h007]  = sectionDesc(12'h456, 2'b11, 4'd2);  // No-access domain
    words[13'h008]  = coarseDesc(22'h51, 4'd3);           // Table at 0x14400
    words[13'h009]  = sectionDesc(12'h999, 2'b11, 4'd1);
    words[13'h00A]  = sectionDesc(12'h321, 2'b10, 4'd1);
    words[13'h1003] = smallDesc(20'h76543, 2'b11);
    words[13'h1007] = largeDesc(16'hBEEF, 2'b11);
    words[13'h1102] = smallDesc(20'h11111, 2'b10);
  end

  assign inTables  = HAddr[31:15] == 17'h0_0002;
  assign HRData    = inTables ? words[HAddr[14:2]] : ~HAddr;
  assign MMUExtInt = HRequest & (HAddr == abortAddr);

  // HReady high for one cycle per beat, after 0 to 3 wait states
  always @(posedge clk, posedge reset) begin
    if (reset) begin
      HReady  <= 1'b0;
      waitCnt <= 2'd0;
    end else if (HReady) begin
      HReady  <= 1'b0;
      waitCnt <= 2'($random(seed));
    end else if (HRequest) begin
      if (waitCnt == 2'd0)
        HReady <= 1'b1;
      else
        waitCnt <= waitCnt - 2'd1;
    end
  end

endmodule

//--- tbMmu.sv
`timescale 1ns/1ps

module tbMmu;

  localparam int accessTimeout = 200;

  typedef struct packed {
    logic        ready;
    logic        fault;
    logic        request;
    logic [3:0]  beats;      // Completed bus beats
    logic [31:0] readyAddr;  // HAddr in the CPUHReady cycle
  } accessResult_t;

  logic          clk = 1'b0;
  logic          reset;
  logic          CPUHRequest, CPUHWrite, WordAccess, SupMode;
  logic [31:0]   CPUHAddr, Cont, Dom;
  logic [17:0]   TBase;
  logic          MMUExtInt, HReady;
  logic [31:0]   HRData, HAddr, FAR;
  logic          HRequest, HWrite, CPUHReady, Fault;
  logic [7:0]    FSR;
  accessResult_t last;

  mmuTop mmuTop_inst (
    .clk(clk), .reset(reset), .CPUHRequest(CPUHRequest), .CPUHWrite(CPUHWrite),
    .WordAccess(WordAccess), .SupMode(SupMode), .CPUHAddr(CPUHAddr), .Cont(Cont),
    .Dom(Dom), .TBase(TBase), .MMUExtInt(MMUExtInt), .HRData(HRData), .HReady(HReady),
    .HAddr(HAddr), .HRequest(HRequest), .HWrite(HWrite), .CPUHReady(CPUHReady),
    .Fault(Fault), .FSR(FSR), .FAR(FAR)
  );

  tbMem memory (
    .clk(clk), .reset(reset), .HAddr(HAddr), .HRequest(HRequest), .HRData(HRData),
    .HReady(HReady), .MMUExtInt(MMUExtInt)
  );

  always #50 clk = ~clk;

  task automatic stopWithError(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual == expected)
      else stopWithError($sformatf("mismatch %s: expected %h, actual %h",
                                   name, expected, actual));
  endtask

  // Control word is registered inside the DUT, so give it time to settle
  task automatic setControl(input logic [31:0] cont);
    @(negedge clk);
    Cont  = cont;
    Dom   = 32'h0000_0047;  // d0 manager, d1 client, d2 no access, d3 client
    TBase = 18'h00004;
    repeat (2) @(negedge clk);
  endtask

  task automatic runAccess(input logic [31:0] addr, input logic write, input logic sup,
                           input logic word, input logic bypass);
    int   cycles;
    logic finished;
    last     = '0;
    finished = 1'b0;
    cycles   = 0;
    @(negedge clk);
    CPUHAddr    = addr;
    CPUHWrite   = write;
    SupMode     = sup;
    WordAccess  = word;
    CPUHRequest = 1'b1;
    while (!finished && cycles < accessTimeout) begin
      @(negedge clk);
      cycles++;
      if (bypass) begin
        checkValue("bypass address", CPUHAddr, HAddr);
        checkValue("bypass ready", 32'(HReady), 32'(CPUHReady));
      end
      if (HRequest)
        last.request = 1'b1;
      if (HRequest && HReady)
        last.beats = last.beats + 4'd1;
      if (CPUHReady) begin
        last.ready     = 1'b1;
        last.readyAddr = HAddr;
        checkValue("data beat write", 32'(write), 32'(HWrite));
      end else if (HRequest && HReady) begin
        checkValue("table fetch write", 32'd0, 32'(HWrite));  // Table fetches only read
      end
      if (Fault)
        last.fault = 1'b1;
      finished = CPUHReady | Fault;
    end
    if (!finished)
      stopWithError($sformatf("timeout: access to %h never ended", addr));
    @(negedge clk);  // FSR and FAR have loaded by now
    CPUHRequest = 1'b0;
  endtask

  task automatic checkTranslated(input string name, input logic [31:0] phys,
                                 input logic [3:0] beatsExp);
    checkValue({name, " ready"}, 32'd1, 32'(last.ready));
    checkValue({name, " fault"}, 32'd0, 32'(last.fault));
    checkValue({name, " address"}, phys, last.readyAddr);
    checkValue({name, " beats"}, 32'(beatsExp), 32'(last.beats));
  endtask

  task automatic checkFaulted(input string name, input logic [3:0] code,
                              input logic [31:0] addr, input logic [3:0] beatsExp);
    checkValue({name, " fault"}, 32'd1, 32'(last.fault));
    checkValue({name, " ready"}, 32'd0, 32'(last.ready));
    checkValue({name, " code"}, 32'(code), 32'(FSR[3:0]));
    checkValue({name, " FAR"}, addr, FAR);
    checkValue({name, " beats"}, 32'(beatsExp), 32'(last.beats));
  endtask

  initial begin
    reset       = 1'b1;
    CPUHRequest = 1'b0;
    CPUHWrite   = 1'b0;
    WordAccess  = 1'b0;
    SupMode     = 1'b0;
    CPUHAddr    = 32'h0;
    Cont        = 32'h0;
    Dom         = 32'h0;
    TBase       = 18'h0;
    last        = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    checkValue("reset HRequest", 32'd0, 32'(HRequest));
    checkValue("reset CPUHReady", 32'd0, 32'(CPUHReady));
    checkValue("reset Fault", 32'd0, 32'(Fault));
    checkValue("reset FSR", 32'd0, 32'(FSR));
    checkValue("reset FAR", 32'd0, FAR);

    // Bypass with a misaligned word included since no check applies
    setControl(32'h0000_0000);
    runAccess(32'h1234_5678, 1'b1, 1'b1, 1'b1, 1'b1);
    checkTranslated("bypass write", 32'h1234_5678, 4'd1);
    runAccess(32'h0000_0102, 1'b0, 1'b0, 1'b1, 1'b1);
    checkTranslated("bypass read", 32'h0000_0102, 4'd1);

    setControl(32'h0000_0001);
    runAccess(32'h0030_1234, 1'b0, 1'b0, 1'b1, 1'b0);
    checkTranslated("section", 32'h80A0_1234, 4'd2);
    runAccess(32'h0040_0ABC, 1'b1, 1'b0, 1'b1, 1'b0);
    checkTranslated("manager section", 32'h1230_0ABC, 4'd2);
    runAccess(32'h0050_3454, 1'b0, 1'b1, 1'b1, 1'b0);
    checkTranslated("small page", 32'h7654_3454, 4'd3);
    runAccess(32'h0050_7ABC, 1'b1, 1'b0, 1'b1, 1'b0);
    checkTranslated("large page", 32'hBEEF_7ABC, 4'd3);

    runAccess(32'h0060_0088, 1'b0, 1'b1, 1'b1, 1'b0);
    checkFaulted("translation", 4'b0101, 32'h0060_0088, 4'd1);
    runAccess(32'h0070_0010, 1'b0, 1'b1, 1'b1, 1'b0);
    checkFaulted("domain", 4'b1001, 32'h0070_0010, 4'd1);
    checkValue("domain FSR", 32'h29, 32'(FSR));

    // User write to AP 10 faults, supervisor write does not
    runAccess(32'h00A0_0040, 1'b1, 1'b0, 1'b1, 1'b0);
    checkFaulted("section permission", 4'b1101, 32'h00A0_0040, 4'd1);
    checkValue("section permission FSR", 32'h1D, 32'(FSR));
    runAccess(32'h00A0_0040, 1'b1, 1'b1, 1'b1, 1'b0);
    checkTranslated("supervisor write", 32'h3210_0040, 4'd2);
    runAccess(32'h0080_2000, 1'b1, 1'b0, 1'b1, 1'b0);
    checkFaulted("page permission", 4'b1111, 32'h0080_2000, 4'd2);
    checkValue("page permission FSR", 32'h3F, 32'(FSR));

    runAccess(32'h0030_1236, 1'b0, 1'b1, 1'b1, 1'b0);
    checkFaulted("alignment", 4'b0001, 32'h0030_1236, 4'd0);
    checkValue("alignment request", 32'd0, 32'(last.request));
    runAccess(32'h0090_0000, 1'b0, 1'b1, 1'b1, 1'b0);
    checkFaulted("external abort", 4'b1100, 32'h0090_0000, 4'd1);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- list.f
mmuPkg.sv
cpuPort.sv
tableWalker.sv
accessCheck.sv
faultReporter.sv
busDriver.sv
mmuTop.sv
tbMem.sv
tbMmu.sv

//--- Makefile
TOP = tbMmu

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
